/* Bender.yml */
package:
  name: sp_fabric

sources:
  - logic/sp_pkg.sv
  - logic/sp_bus_fabric.sv
  - logic/sp_local_mem.sv
  - logic/sp_mmio_regs.sv
  - logic/sp_byte_bridge.sv
  - logic/sp_top.sv
  - target: test
    files:
      - test/sp_tb.sv

/* logic/sp_bus_fabric.sv */
module sp_bus_fabric import sp_pkg::*; (
   input  logic    clk,
   input  logic    rst_n_i,
   input  wb_req_t host_req_i,
   output wb_rsp_t host_rsp_o,
   output wb_req_t mem_req_o,
   output wb_req_t mmio_req_o,
   output wb_req_t bridge_req_o,
   input  wb_rsp_t mem_rsp_i,
   input  wb_rsp_t mmio_rsp_i,
   input  wb_rsp_t bridge_rsp_i
);

   sp_target_e tgt;
   logic       dflt_ack_q;

   // the top address bit alone selects local memory.
   always_comb begin
      if (!host_req_i.adr[31]) begin
         tgt = tgt_mem;
      end else if (host_req_i.adr[31:24] == bridge_page) begin
         tgt = tgt_bridge;
      end else if (host_req_i.adr[31:24] == mmio_page) begin
         tgt = tgt_mmio;
      end else begin
         tgt = tgt_none;
      end
   end

   always_comb begin
      mem_req_o        = host_req_i;
      mmio_req_o       = host_req_i;
      bridge_req_o     = host_req_i;
      mem_req_o.stb    = host_req_i.stb && (tgt == tgt_mem);
      mmio_req_o.stb   = host_req_i.stb && (tgt == tgt_mmio);
      bridge_req_o.stb = host_req_i.stb && (tgt == tgt_bridge);
   end

   // unmapped accesses get a zero-data ack one cycle after the strobe.
   always_ff @(posedge clk) begin
      if (!rst_n_i || dflt_ack_q) begin
         dflt_ack_q <= 1'b0;
      end else begin
         dflt_ack_q <= host_req_i.cyc && host_req_i.stb && (tgt == tgt_none);
      end
   end

   always_comb begin
      case (tgt)
         tgt_mem:    host_rsp_o = mem_rsp_i;
         tgt_bridge: host_rsp_o = bridge_rsp_i;
         tgt_mmio:   host_rsp_o = mmio_rsp_i;
         default: begin
            host_rsp_o.ack = dflt_ack_q;
            host_rsp_o.dat = '0;
         end
      endcase
   end

   // only one responder may answer, or the host would take a foreign ack.
   a_single_ack: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      $onehot0({mem_rsp_i.ack, mmio_rsp_i.ack, bridge_rsp_i.ack, dflt_ack_q})
   );

endmodule

/* logic/sp_byte_bridge.sv */
module sp_byte_bridge import sp_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  wb_req_t   req_i,
   output wb_rsp_t   rsp_o,
   output byte_req_t ext_req_o,
   input  byte_rsp_t ext_rsp_i
);

   logic [1:0]  lane_q;
   logic [31:0] shift_q;
   logic        ack_q;
   logic        active;
   logic        ext_run;
   logic        byte_done;

   assign active = req_i.cyc && req_i.stb;

   // the external cycle ends with the host ack or when the host gives up.
   assign ext_run   = active && !ack_q;
   assign byte_done = ext_run && ext_rsp_i.ack;

   // inverting the lane gives the big-endian byte position in the word.
   always_comb begin
      ext_req_o.cyc = ext_run;
      ext_req_o.stb = ext_run;
      ext_req_o.we  = req_i.we;
      ext_req_o.sel = req_i.sel[~lane_q];
      ext_req_o.adr = {req_i.adr[23:2], lane_q};
      ext_req_o.dat = req_i.dat[{~lane_q, 3'b000} +: 8];
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i || ack_q || !active) begin
         lane_q <= 2'd0;
         ack_q  <= 1'b0;
      end else if (byte_done) begin
         lane_q <= lane_q + 2'd1;
         if (lane_q == 2'd3) begin
            ack_q <= 1'b1;
         end
      end
   end

   // lane 0 arrives first and ends up in the top byte.
   always_ff @(posedge clk) begin
      if (byte_done) begin
         shift_q <= {shift_q[23:0], ext_rsp_i.dat};
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = shift_q;

   a_stb_in_cyc: assert property (
      @(posedge clk) disable iff (!rst_n_i) ext_req_o.stb |-> ext_req_o.cyc
   );

endmodule

/* logic/sp_local_mem.sv */
module sp_local_mem import sp_pkg::*; #(
   parameter int mem_words = 256
) (
   input  logic    clk,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   localparam int aw = $clog2(mem_words);

   logic [31:0]   mem_q [mem_words];
   logic [31:0]   rd_q;
   logic          ack_q;
   logic          access;
   logic [aw-1:0] idx;

   // a new access starts only while no ack is pending.
   assign access = req_i.cyc && req_i.stb && !ack_q;
   assign idx    = req_i.adr[aw+1:2];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // sel bit i covers data bits 8*i and up, so sel[3] is lane 0.
   always_ff @(posedge clk) begin
      if (access && req_i.we) begin
         for (int i = 0; i < 4; i++) begin
            if (req_i.sel[i]) begin
               mem_q[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rd_q <= mem_q[idx];
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = rd_q;

endmodule

/* logic/sp_mmio_regs.sv */
module sp_mmio_regs import sp_pkg::*; (
   input  logic       clk,
   input  logic       rst_n_i,
   input  wb_req_t    req_i,
   output wb_rsp_t    rsp_o,
   output logic [7:0] led_o,
   input  logic [7:0] sw_i
);

   logic        ack_q;
   logic        access;
   logic        wr_en;
   logic [7:0]  ofs;
   logic [7:0]  ofs_q;
   logic [7:0]  led_q;
   logic [31:0] scratch_q;

   assign access = req_i.cyc && req_i.stb && !ack_q;
   assign wr_en  = access && req_i.we;
   assign ofs    = req_i.adr[7:0];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         ofs_q <= ofs;
      end
   end

   // the led register sits in byte lane 3, the low byte of the word.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         led_q <= '0;
      end else if (wr_en && ofs == led_ofs && req_i.sel[0]) begin
         led_q <= req_i.dat[7:0];
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && ofs == scratch_ofs) begin
         for (int i = 0; i < 4; i++) begin
            if (req_i.sel[i]) begin
               scratch_q[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
         end
      end
   end

   // status reflects the switches as they are in the ack cycle.
   always_comb begin
      case (ofs_q)
         led_ofs:     rsp_o.dat = {24'h0, led_q};
         scratch_ofs: rsp_o.dat = scratch_q;
         status_ofs:  rsp_o.dat = {24'h0, sw_i};
         default:     rsp_o.dat = '0;
      endcase
   end

   assign rsp_o.ack = ack_q;
   assign led_o     = led_q;

   a_ack_pulse: assert property (
      @(posedge clk) disable iff (!rst_n_i) ack_q |=> !ack_q
   );

endmodule

/* logic/sp_pkg.sv */
package sp_pkg;

   // 32-bit Wishbone classic request from the host and toward each slave.
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   // external 8-bit Wishbone bus behind the byte bridge.
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic        sel;
      logic [23:0] adr;
      logic [7:0]  dat;
   } byte_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } byte_rsp_t;

   typedef enum logic [1:0] {
      tgt_mem    = 2'd0,
      tgt_bridge = 2'd1,
      tgt_mmio   = 2'd2,
      tgt_none   = 2'd3
   } sp_target_e;

   // top address byte of each mapped page.
   parameter logic [7:0] bridge_page = 8'h80;
   parameter logic [7:0] mmio_page   = 8'hff;

   // word offsets inside the register page.
   parameter logic [7:0] led_ofs     = 8'd0;
   parameter logic [7:0] scratch_ofs = 8'd4;
   parameter logic [7:0] status_ofs  = 8'd8;

endpackage

/* logic/sp_top.sv */
module sp_top import sp_pkg::*; #(
   parameter int mem_words = 256
) (
   input  logic       clk,
   input  logic       rst_n_i,
   input  wb_req_t    host_req_i,
   output wb_rsp_t    host_rsp_o,
   output byte_req_t  ext_req_o,
   input  byte_rsp_t  ext_rsp_i,
   output logic [7:0] led_o,
   input  logic [7:0] sw_i
);

   wb_req_t mem_req;
   wb_req_t mmio_req;
   wb_req_t bridge_req;
   wb_rsp_t mem_rsp;
   wb_rsp_t mmio_rsp;
   wb_rsp_t bridge_rsp;

   sp_bus_fabric u_fabric (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .host_req_i   (host_req_i),
      .host_rsp_o   (host_rsp_o),
      .mem_req_o    (mem_req),
      .mmio_req_o   (mmio_req),
      .bridge_req_o (bridge_req),
      .mem_rsp_i    (mem_rsp),
      .mmio_rsp_i   (mmio_rsp),
      .bridge_rsp_i (bridge_rsp)
   );

   sp_local_mem #(
      .mem_words (mem_words)
   ) u_mem (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (mem_req),
      .rsp_o   (mem_rsp)
   );

   sp_mmio_regs u_mmio (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (mmio_req),
      .rsp_o   (mmio_rsp),
      .led_o   (led_o),
      .sw_i    (sw_i)
   );

   sp_byte_bridge u_bridge (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .req_i     (bridge_req),
      .rsp_o     (bridge_rsp),
      .ext_req_o (ext_req_o),
      .ext_rsp_i (ext_rsp_i)
   );

endmodule

/* sp_top.f */
logic/sp_pkg.sv
logic/sp_bus_fabric.sv
logic/sp_local_mem.sv
logic/sp_mmio_regs.sv
logic/sp_byte_bridge.sv
logic/sp_top.sv
test/sp_tb.sv

/* test/sp_tb.sv */
module sp_tb import sp_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   logic        clk;
   logic        rst_n;
   wb_req_t     host_req;
   wb_rsp_t     host_rsp;
   byte_req_t   ext_req;
   byte_rsp_t   ext_rsp;
   logic [7:0]  led;
   logic [7:0]  sw;
   logic [7:0]  byte_mem [4];
   logic [23:0] xfer_adr [$];
   logic        xfer_sel [$];
   logic [7:0]  xfer_dat [$];
   integer      seed = 32'hf206_ff69;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;
   int          tests_bad = 0;
   int          acks_given = 0;
   int          xfers_at_ack;

   sp_top #(.mem_words(256)) u_dut (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .host_req_i (host_req),
      .host_rsp_o (host_rsp),
      .ext_req_o  (ext_req),
      .ext_rsp_i  (ext_rsp),
      .led_o      (led),
      .sw_i       (sw)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   a_ack_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) host_rsp.ack |=> !host_rsp.ack
   ) else begin
      $display("Host ack stayed high for more than one cycle at %0t", $time);
      errors++;
   end

   a_ext_idle: assert property (
      @(posedge clk) disable iff (!rst_n) !host_req.cyc |-> !ext_req.cyc
   ) else begin
      $display("External cycle active while the host bus is idle at %0t", $time);
      errors++;
   end

   // byte slave that answers each strobe after 0 to 3 wait states.
   initial begin : byte_responder
      logic [1:0] lane;
      integer     rnd;
      int         waits;
      ext_rsp = '0;
      forever begin
         @(negedge clk);
         if (ext_req.cyc && ext_req.stb) begin
            lane = ext_req.adr[1:0];
            xfer_adr.push_back(ext_req.adr);
            xfer_sel.push_back(ext_req.sel);
            xfer_dat.push_back(ext_req.dat);
            if (ext_req.we && ext_req.sel) begin
               byte_mem[lane] = ext_req.dat;
            end
            rnd = $random(seed);
            waits = rnd[1:0];
            repeat (waits) @(posedge clk);
            @(posedge clk);
            #2;
            ext_rsp.ack = 1'b1;
            ext_rsp.dat = byte_mem[lane];
            acks_given++;
            @(posedge clk);
            #2;
            ext_rsp = '0;
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_errors) begin
         tests_bad++;
      end
      $display("test %-10s %s", name, (errors == test_errors) ? "ok" : "has errors");
      test_errors = errors;
   endtask

   // one classic access; the request is held until ack is seen.
   task automatic host_access(input string name, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat, output int cycles);
      @(posedge clk);
      #2;
      host_req.cyc = 1'b1;
      host_req.stb = 1'b1;
      host_req.we  = we;
      host_req.sel = sel;
      host_req.adr = adr;
      host_req.dat = wdat;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!host_rsp.ack && cycles < 200);
      if (!host_rsp.ack) begin
         $display("Timeout in test %s: the host access at %h was never acknowledged",
                  name, adr);
         errors++;
      end
      rdat = host_rsp.dat;
      xfers_at_ack = acks_given;
      @(posedge clk);
      #2;
      host_req = '0;
   endtask

   initial begin : main
      logic [31:0] rd;
      logic [31:0] wr;
      int          cyc;
      integer      rnd;
      host_req = '0;
      sw       = 8'h00;
      rst_n    = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      check_value("reset ack", 0, host_rsp.ack);
      check_value("reset ext", 0, {ext_req.cyc, ext_req.stb});
      check_value("reset led", 0, led);
      end_test("reset");

      host_access("mem", 1'b1, 4'hf, 32'h0000_0040, 32'h1234_5678, rd, cyc);
      check_value("mem wr latency", 2, cyc);
      host_access("mem", 1'b0, 4'hf, 32'h0000_0040, 32'h0, rd, cyc);
      check_value("mem read", 32'h1234_5678, rd);
      check_value("mem rd latency", 2, cyc);
      // sel bit 1 is byte lane 2, bits 15..8.
      host_access("mem", 1'b1, 4'b0010, 32'h0000_0040, 32'hdead_beef, rd, cyc);
      host_access("mem", 1'b0, 4'hf, 32'h0000_0040, 32'h0, rd, cyc);
      check_value("mem lane 2", 32'h1234_be78, rd);
      end_test("mem");

      xfer_adr.delete();
      xfer_sel.delete();
      xfer_dat.delete();
      acks_given = 0;
      wr = 32'hcafe_f00d;
      host_access("bridge_wr", 1'b1, 4'b1011, 32'h8012_3458, wr, rd, cyc);
      check_value("bridge_wr count", 4, xfer_adr.size());
      check_value("bridge_wr acks", 4, xfers_at_ack);
      for (int i = 0; i < 4 && i < xfer_adr.size(); i++) begin
         check_value("bridge_wr adr", {8'h0, 22'h04_8d16, 2'(i)}, xfer_adr[i]);
         check_value("bridge_wr dat", wr[8*(3-i) +: 8], xfer_dat[i]);
         check_value("bridge_wr sel", 4'b1011 >> (3 - i) & 1, xfer_sel[i]);
      end
      // the responder stores only bytes that arrive as writes.
      check_value("bridge_wr lane 0", wr[31:24], byte_mem[0]);
      check_value("bridge_wr lane 2", wr[15:8], byte_mem[2]);
      check_value("bridge_wr lane 3", wr[7:0], byte_mem[3]);
      end_test("bridge_wr");

      for (int i = 0; i < 4; i++) begin
         rnd = $random(seed);
         byte_mem[i] = rnd[7:0];
      end
      host_access("bridge_rd", 1'b0, 4'hf, 32'h8000_0010, 32'h0, rd, cyc);
      check_value("bridge_rd", {byte_mem[0], byte_mem[1], byte_mem[2], byte_mem[3]}, rd);
      end_test("bridge_rd");

      sw = 8'h3c;
      host_access("mmio", 1'b1, 4'hf, 32'hff00_0000, 32'h0000_00a5, rd, cyc);
      check_value("mmio led", 8'ha5, led);
      host_access("mmio", 1'b1, 4'hf, 32'hff00_0004, 32'h0bad_cafe, rd, cyc);
      host_access("mmio", 1'b0, 4'hf, 32'hff00_0004, 32'h0, rd, cyc);
      check_value("mmio scratch", 32'h0bad_cafe, rd);
      host_access("mmio", 1'b0, 4'hf, 32'hff00_0008, 32'h0, rd, cyc);
      check_value("mmio status", {24'h0, sw}, rd);
      host_access("mmio", 1'b1, 4'hf, 32'hff00_0008, 32'hffff_ffff, rd, cyc);
      host_access("mmio", 1'b0, 4'hf, 32'hff00_0008, 32'h0, rd, cyc);
      check_value("mmio status ro", {24'h0, sw}, rd);
      end_test("mmio");

      xfer_adr.delete();
      host_access("unmapped", 1'b1, 4'hf, 32'hc000_0000, 32'h0000_005a, rd, cyc);
      host_access("unmapped", 1'b0, 4'hf, 32'hc000_0000, 32'h0, rd, cyc);
      check_value("unmapped data", 0, rd);
      check_value("unmapped ext", 0, xfer_adr.size());
      check_value("unmapped led", 8'ha5, led);
      end_test("unmapped");

      $display("tests run %0d, tests with errors %0d, errors %0d",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
